// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_cpu_id
FILELIST = cpu_id.f
HEADERS  = cpu_id_macros.svh tb_cpu_id_model.svh
SOURCES  = $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== cpu_id.f ====
+incdir+.
cpu_id_pkg.sv
id_decoder.sv
id_regfile.sv
id_operand_unit.sv
id_stage_reg.sv
cpu_id.sv
tb_cpu_id.sv

// ==== cpu_id.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_id
    import cpu_id_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     reset_i,
    input  wire word_t    pc_i,
    input  wire word_t    ir_i,
    input  wire ex_fwd_t  ex_fwd_i,
    input  wire wb_port_t wb_i,
    output logic          ready_o,
    output logic          jmp_valid_o,
    output word_t         jmp_addr_o,
    output id_out_t       out_o
);

    instr_fields_t fields;
    ctrl_word_t    cw;
    word_t         ra;
    word_t         rb;
    word_t         op1;
    word_t         op2;
    word_t         store_data;
    logic          bubble;
    logic          jmp_valid;

    id_decoder u_decoder (
        .ir_i     (ir_i),
        .fields_o (fields),
        .cw_o     (cw)
    );

    id_regfile u_regfile (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .rs1_i   (fields.rs1),
        .rs2_i   (fields.rs2),
        .ra_o    (ra),
        .rb_o    (rb),
        .wb_i    (wb_i)
    );

    id_operand_unit u_operand_unit (
        .pc_i         (pc_i),
        .fields_i     (fields),
        .cw_i         (cw),
        .ra_i         (ra),
        .rb_i         (rb),
        .ex_fwd_i     (ex_fwd_i),
        .wb_i         (wb_i),
        .op1_o        (op1),
        .op2_o        (op2),
        .store_data_o (store_data),
        .bubble_o     (bubble),
        .jmp_valid_o  (jmp_valid),
        .jmp_addr_o   (jmp_addr_o)
    );

    id_stage_reg u_stage_reg (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .pc_i         (pc_i),
        .ir_i         (ir_i),
        .cw_i         (cw),
        .rd_i         (fields.rd),
        .op1_i        (op1),
        .op2_i        (op2),
        .store_data_i (store_data),
        .bubble_i     (bubble),
        .out_o        (out_o)
    );

    // upstream sees an idle, willing stage while in reset
    assign ready_o     = reset_i || !bubble;
    assign jmp_valid_o = !reset_i && jmp_valid;

endmodule

`default_nettype wire

// ==== cpu_id_macros.svh ====
`ifndef CPU_ID_MACROS_SVH
`define CPU_ID_MACROS_SVH

// datapath width
`define CPU_XLEN 32

// register file geometry
`define CPU_NREGS 32
`define CPU_RAW 5

// addi x0, x0, 0
`define CPU_NOP_IR 32'h0000_0013

// bytes per instruction
`define CPU_PC_STEP 32'd4

`endif

// ==== cpu_id_pkg.sv ====
`default_nettype none

`include "cpu_id_macros.svh"

package cpu_id_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [`CPU_RAW-1:0]  regaddr_t;

    // RV32I major opcodes kept by this stage
    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_MISC_MEM = 7'b0001111,
        OP_IMM      = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_STORE    = 7'b0100011,
        OP          = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111
    } opcode_t;

    // {funct7[0], funct7[5], funct3}
    typedef enum logic [4:0] {
        ALU_ADD   = 5'b00000,
        ALU_SLL   = 5'b00001,
        ALU_SLT   = 5'b00010,
        ALU_SLTU  = 5'b00011,
        ALU_XOR   = 5'b00100,
        ALU_SRL   = 5'b00101,
        ALU_OR    = 5'b00110,
        ALU_AND   = 5'b00111,
        ALU_SUB   = 5'b01000,
        ALU_SRA   = 5'b01101,
        ALU_COPY1 = 5'b11000, // no legal funct7 maps here
        ALU_X     = 5'b11111
    } alu_mode_t;

    typedef enum logic [1:0] {ALU_OP1_X, ALU_OP1_RS1, ALU_OP1_IMMU} alu_op1_sel_t;

    typedef enum logic [2:0] {
        ALU_OP2_X, ALU_OP2_RS2, ALU_OP2_IMMI, ALU_OP2_IMMS, ALU_OP2_PC
    } alu_op2_sel_t;

    typedef enum logic [1:0] {PC_NEXT, PC_JUMP_REL, PC_JUMP_ABS, PC_BRANCH} pc_mode_t;
    typedef enum logic [1:0] {MA_X, MA_LOAD, MA_STORE} ma_mode_t;

    // same codes as the load/store funct3
    typedef enum logic [2:0] {
        MA_SIZE_B  = 3'b000,
        MA_SIZE_H  = 3'b001,
        MA_SIZE_W  = 3'b010,
        MA_SIZE_BU = 3'b100,
        MA_SIZE_HU = 3'b101,
        MA_SIZE_X  = 3'b111
    } ma_size_t;

    typedef enum logic [1:0] {WB_SRC_X, WB_SRC_ALU, WB_SRC_MEM, WB_SRC_PC4} wb_src_t;

    typedef struct packed {
        logic         halt;
        pc_mode_t     pc_mode;
        alu_op1_sel_t alu_op1;
        alu_op2_sel_t alu_op2;
        alu_mode_t    alu_mode;
        ma_mode_t     ma_mode;
        ma_size_t     ma_size;
        wb_src_t      wb_src;
        logic         ra_used;
        logic         rb_used;
    } ctrl_word_t;

    typedef struct packed {
        regaddr_t   rs1;
        regaddr_t   rs2;
        regaddr_t   rd;
        logic [2:0] funct3;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
    } instr_fields_t;

    // result of the instruction now in execute
    typedef struct packed {
        logic     valid;
        logic     ready; // data already computed
        regaddr_t addr;
        word_t    data;
    } ex_fwd_t;

    typedef struct packed {
        logic     valid;
        regaddr_t addr;
        word_t    data;
    } wb_port_t;

    typedef struct packed {
        word_t     pc;
        word_t     ir;
        word_t     alu_op1;
        word_t     alu_op2;
        alu_mode_t alu_mode;
        ma_mode_t  ma_mode;
        ma_size_t  ma_size;
        word_t     ma_data;  // store data
        wb_src_t   wb_src;
        word_t     wb_data;  // return address for jal/jalr
        logic      wb_valid;
        logic      halt;
    } id_out_t;

endpackage

`default_nettype wire

// ==== id_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_decoder
    import cpu_id_pkg::*;
(
    input  wire word_t    ir_i,
    output instr_fields_t fields_o,
    output ctrl_word_t    cw_o
);

    opcode_t    opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    alu_mode_t  mode3; // plain immediate ops
    alu_mode_t  mode7; // reg-reg ops and srli/srai
    ctrl_word_t cw;

    always_comb begin
        opcode = opcode_t'(ir_i[6:0]);
        funct3 = ir_i[14:12];
        funct7 = ir_i[31:25];

        fields_o.rd     = ir_i[11:7];
        fields_o.funct3 = funct3;
        fields_o.rs1    = ir_i[19:15];
        fields_o.rs2    = ir_i[24:20];

        // sign bit is always ir[31]
        fields_o.imm_i = {{21{ir_i[31]}}, ir_i[30:20]};
        fields_o.imm_s = {{21{ir_i[31]}}, ir_i[30:25], ir_i[11:7]};
        fields_o.imm_b = {{20{ir_i[31]}}, ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
        fields_o.imm_u = {ir_i[31:12], 12'b0};
        fields_o.imm_j = {{12{ir_i[31]}}, ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

        mode7 = alu_mode_t'({funct7[0], funct7[5], funct3});
        mode3 = alu_mode_t'({2'b00, funct3});
    end

    always_comb begin
        cw.halt     = 1'b0;
        cw.pc_mode  = PC_NEXT;
        cw.alu_op1  = ALU_OP1_X;
        cw.alu_op2  = ALU_OP2_X;
        cw.alu_mode = ALU_X;
        cw.ma_mode  = MA_X;
        cw.ma_size  = MA_SIZE_X;
        cw.wb_src   = WB_SRC_X;
        cw.ra_used  = 1'b0;
        cw.rb_used  = 1'b0;

        case (opcode)
            OP_IMM: begin
                cw.alu_op1 = ALU_OP1_RS1;
                cw.alu_op2 = ALU_OP2_IMMI;
                // shift right kind lives in funct7
                if (funct3 == 3'b101 && funct7 ==? 7'b0?00000)
                    cw.alu_mode = mode7;
                else
                    cw.alu_mode = mode3;
                cw.wb_src  = WB_SRC_ALU;
                cw.ra_used = 1'b1;
            end
            OP: begin
                cw.alu_op1  = ALU_OP1_RS1;
                cw.alu_op2  = ALU_OP2_RS2;
                cw.alu_mode = mode7;
                cw.wb_src   = WB_SRC_ALU;
                cw.ra_used  = 1'b1;
                cw.rb_used  = 1'b1;
            end
            OP_LUI: begin
                cw.alu_op1  = ALU_OP1_IMMU;
                cw.alu_op2  = ALU_OP2_RS2;
                cw.alu_mode = ALU_COPY1; // op2 ignored by the ALU
                cw.wb_src   = WB_SRC_ALU;
                cw.rb_used  = 1'b1;
            end
            OP_AUIPC: begin
                cw.alu_op1  = ALU_OP1_IMMU;
                cw.alu_op2  = ALU_OP2_PC;
                cw.alu_mode = ALU_ADD;
                cw.wb_src   = WB_SRC_ALU;
            end
            OP_JAL: begin
                cw.pc_mode = PC_JUMP_REL;
                cw.wb_src  = WB_SRC_PC4;
            end
            OP_JALR: begin
                cw.pc_mode = PC_JUMP_ABS;
                cw.wb_src  = WB_SRC_PC4;
                cw.ra_used = 1'b1;
            end
            OP_BRANCH: begin
                if (funct3[2:1] == 2'b01) begin
                    cw.halt = 1'b1; // no such branch
                end else begin
                    cw.pc_mode = PC_BRANCH;
                    cw.ra_used = 1'b1;
                    cw.rb_used = 1'b1;
                end
            end
            OP_LOAD, OP_STORE: begin
                cw.alu_op1  = ALU_OP1_RS1;
                cw.alu_op2  = (opcode == OP_STORE) ? ALU_OP2_IMMS : ALU_OP2_IMMI;
                cw.alu_mode = ALU_ADD;
                cw.ma_mode  = (opcode == OP_STORE) ? MA_STORE : MA_LOAD;
                cw.ma_size  = ma_size_t'(funct3);
                cw.wb_src   = (opcode == OP_STORE) ? WB_SRC_X : WB_SRC_MEM;
                cw.ra_used  = 1'b1;
                cw.rb_used  = 1'b1;
            end
            OP_MISC_MEM: ; // fence is a nop here
            default: cw.halt = 1'b1; // incl. SYSTEM
        endcase
    end

    // x0 never causes a hazard
    always_comb begin
        cw_o         = cw;
        cw_o.ra_used = cw.ra_used && (fields_o.rs1 != '0);
        cw_o.rb_used = cw.rb_used && (fields_o.rs2 != '0);
    end

    always_comb begin
        assert final (cw_o.alu_op2 != ALU_OP2_IMMS || opcode == OP_STORE)
            else $error("imm_s selected for opcode %b", opcode);
    end

endmodule

`default_nettype wire

// ==== id_operand_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_operand_unit
    import cpu_id_pkg::*;
(
    input  wire word_t         pc_i,
    input  wire instr_fields_t fields_i,
    input  wire ctrl_word_t    cw_i,
    input  wire word_t         ra_i,
    input  wire word_t         rb_i,
    input  wire ex_fwd_t       ex_fwd_i,
    input  wire wb_port_t      wb_i,
    output word_t              op1_o,
    output word_t              op2_o,
    output word_t              store_data_o,
    output logic               bubble_o,
    output logic               jmp_valid_o,
    output word_t              jmp_addr_o
);

    word_t ra_byp;
    word_t rb_byp;
    logic  ra_hazard;
    logic  rb_hazard;
    logic  cmp;
    logic  taken;

    // newest producer wins, x0 stays zero
    function automatic word_t bypass(regaddr_t idx, word_t rf_val, ex_fwd_t ex, wb_port_t wb);
        word_t val;
        if (idx == '0)
            val = rf_val;
        else if (ex.valid && ex.addr == idx)
            val = ex.data;
        else if (wb.valid && wb.addr == idx)
            val = wb.data;
        else
            val = rf_val;
        return val;
    endfunction

    assign ra_byp       = bypass(fields_i.rs1, ra_i, ex_fwd_i, wb_i);
    assign rb_byp       = bypass(fields_i.rs2, rb_i, ex_fwd_i, wb_i);
    assign store_data_o = rb_byp;

    // load in execute, value not there yet
    assign ra_hazard = cw_i.ra_used && ex_fwd_i.valid && !ex_fwd_i.ready
                       && (ex_fwd_i.addr == fields_i.rs1);
    assign rb_hazard = cw_i.rb_used && ex_fwd_i.valid && !ex_fwd_i.ready
                       && (ex_fwd_i.addr == fields_i.rs2);
    assign bubble_o  = ra_hazard || rb_hazard;

    always_comb begin
        case (cw_i.alu_op1)
            ALU_OP1_RS1:  op1_o = ra_byp;
            ALU_OP1_IMMU: op1_o = fields_i.imm_u;
            default:      op1_o = '0;
        endcase
        case (cw_i.alu_op2)
            ALU_OP2_RS2:  op2_o = rb_byp;
            ALU_OP2_IMMI: op2_o = fields_i.imm_i;
            ALU_OP2_IMMS: op2_o = fields_i.imm_s;
            ALU_OP2_PC:   op2_o = pc_i;
            default:      op2_o = '0;
        endcase
    end

    always_comb begin
        case (fields_i.funct3[2:1])
            2'b00:   cmp = (ra_byp == rb_byp);
            2'b10:   cmp = ($signed(ra_byp) < $signed(rb_byp));
            2'b11:   cmp = (ra_byp < rb_byp);
            default: cmp = 1'b0;
        endcase
        // funct3[0] inverts, codes 2 and 3 stay not taken
        taken = (fields_i.funct3[2:1] != 2'b01) && (cmp ^ fields_i.funct3[0]);
    end

    always_comb begin
        case (cw_i.pc_mode)
            PC_JUMP_REL: begin
                jmp_valid_o = 1'b1; // jal needs no register
                jmp_addr_o  = pc_i + fields_i.imm_j;
            end
            PC_JUMP_ABS: begin
                jmp_valid_o = !bubble_o;
                jmp_addr_o  = ra_byp + fields_i.imm_i;
            end
            PC_BRANCH: begin
                jmp_valid_o = taken && !bubble_o;
                jmp_addr_o  = pc_i + fields_i.imm_b;
            end
            default: begin
                jmp_valid_o = 1'b0;
                jmp_addr_o  = '0;
            end
        endcase
    end

    always_comb begin
        assert final (!jmp_valid_o || cw_i.pc_mode != PC_NEXT)
            else $error("jump raised for a sequential instruction");
    end

endmodule

`default_nettype wire

// ==== id_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_id_macros.svh"

module id_regfile
    import cpu_id_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     reset_i,
    input  wire regaddr_t rs1_i,
    input  wire regaddr_t rs2_i,
    output word_t         ra_o,
    output word_t         rb_o,
    input  wire wb_port_t wb_i
);

    word_t regs [`CPU_NREGS];
    logic  we;

    assign we = wb_i.valid && (wb_i.addr != '0);

    always_ff @(posedge clk_i) begin
        if (we)
            regs[wb_i.addr] <= wb_i.data;
    end

    // entry 0 is never written, mux it out
    assign ra_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rb_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    a_x0_untouched: assert property (@(posedge clk_i) disable iff (reset_i)
        $stable(regs[0]))
        else $error("register file entry 0 was written");

endmodule

`default_nettype wire

// ==== id_stage_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_id_macros.svh"

module id_stage_reg
    import cpu_id_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       reset_i,
    input  wire word_t      pc_i,
    input  wire word_t      ir_i,
    input  wire ctrl_word_t cw_i,
    input  wire regaddr_t   rd_i,
    input  wire word_t      op1_i,
    input  wire word_t      op2_i,
    input  wire word_t      store_data_i,
    input  wire logic       bubble_i,
    output id_out_t         out_o
);

    id_out_t nop;
    id_out_t dec;

    always_comb begin
        nop.pc       = '0;
        nop.ir       = `CPU_NOP_IR;
        nop.alu_op1  = '0;
        nop.alu_op2  = '0;
        nop.alu_mode = ALU_ADD;
        nop.ma_mode  = MA_X;
        nop.ma_size  = MA_SIZE_X;
        nop.ma_data  = '0;
        nop.wb_src   = WB_SRC_X;
        nop.wb_data  = '0;
        nop.wb_valid = 1'b0;
        nop.halt     = 1'b0;
    end

    always_comb begin
        dec.pc       = pc_i;
        dec.ir       = ir_i;
        dec.alu_op1  = op1_i;
        dec.alu_op2  = op2_i;
        dec.alu_mode = cw_i.alu_mode;
        dec.ma_mode  = cw_i.ma_mode;
        dec.ma_size  = cw_i.ma_size;
        dec.ma_data  = store_data_i;
        dec.wb_src   = cw_i.wb_src;
        dec.wb_data  = pc_i + `CPU_PC_STEP; // link address
        dec.wb_valid = (cw_i.wb_src != WB_SRC_X) && (rd_i != '0);
        dec.halt     = cw_i.halt;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || bubble_i)
            out_o <= nop;
        else
            out_o <= dec;
    end

endmodule

`default_nettype wire

// ==== tb_cpu_id_model.svh ====
`ifndef TB_CPU_ID_MODEL_SVH
`define TB_CPU_ID_MODEL_SVH

// shadow copy of x0..x7, the only registers the stimulus touches
word_t shadow_regs [8] = '{default: '0};

function automatic word_t imm_i_of(word_t ir);
    return {{20{ir[31]}}, ir[31:20]};
endfunction

function automatic word_t imm_s_of(word_t ir);
    return {{20{ir[31]}}, ir[31:25], ir[11:7]};
endfunction

function automatic word_t imm_b_of(word_t ir);
    return {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
endfunction

function automatic word_t imm_u_of(word_t ir);
    return {ir[31:12], 12'h000};
endfunction

function automatic word_t imm_j_of(word_t ir);
    return {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
endfunction

// ex result first, then the write-back port, then the array
function automatic word_t forwarded_value(regaddr_t a, ex_fwd_t ex, wb_port_t wb);
    if (a == 5'd0)
        return '0;
    if (ex.valid && ex.addr == a)
        return ex.data;
    if (wb.valid && wb.addr == a)
        return wb.data;
    return shadow_regs[a[2:0]];
endfunction

task automatic commit_write(wb_port_t wb);
    if (wb.valid && wb.addr != 5'd0)
        shadow_regs[wb.addr[2:0]] = wb.data;
endtask

function automatic ctrl_word_t expect_ctrl(word_t ir);
    ctrl_word_t c;
    logic [2:0] f3;
    f3 = ir[14:12];
    c = '0;
    c.alu_mode = ALU_X;
    c.ma_size  = MA_SIZE_X;
    case (ir[6:0])
        7'b0010011: begin // op-imm
            c.alu_op1 = ALU_OP1_RS1;
            c.alu_op2 = ALU_OP2_IMMI;
            c.wb_src  = WB_SRC_ALU;
            c.ra_used = 1'b1;
            if (f3 == 3'b101 && ir[31] == 1'b0 && ir[29:25] == 5'd0)
                c.alu_mode = alu_mode_t'({1'b0, ir[30], f3});
            else
                c.alu_mode = alu_mode_t'({2'b00, f3});
        end
        7'b0110011: begin // op
            c.alu_op1  = ALU_OP1_RS1;
            c.alu_op2  = ALU_OP2_RS2;
            c.alu_mode = alu_mode_t'({ir[25], ir[30], f3});
            c.wb_src   = WB_SRC_ALU;
            c.ra_used  = 1'b1;
            c.rb_used  = 1'b1;
        end
        7'b0110111: begin // lui
            c.alu_op1  = ALU_OP1_IMMU;
            c.alu_op2  = ALU_OP2_RS2;
            c.alu_mode = ALU_COPY1;
            c.wb_src   = WB_SRC_ALU;
            c.rb_used  = 1'b1;
        end
        7'b0010111: begin // auipc
            c.alu_op1  = ALU_OP1_IMMU;
            c.alu_op2  = ALU_OP2_PC;
            c.alu_mode = ALU_ADD;
            c.wb_src   = WB_SRC_ALU;
        end
        7'b1101111: begin // jal
            c.pc_mode = PC_JUMP_REL;
            c.wb_src  = WB_SRC_PC4;
        end
        7'b1100111: begin // jalr
            c.pc_mode = PC_JUMP_ABS;
            c.wb_src  = WB_SRC_PC4;
            c.ra_used = 1'b1;
        end
        7'b1100011: begin
            if (f3 == 3'd2 || f3 == 3'd3) begin
                c.halt = 1'b1;
            end else begin
                c.pc_mode = PC_BRANCH;
                c.ra_used = 1'b1;
                c.rb_used = 1'b1;
            end
        end
        7'b0000011, 7'b0100011: begin // load, store
            c.alu_op1  = ALU_OP1_RS1;
            c.alu_op2  = ir[5] ? ALU_OP2_IMMS : ALU_OP2_IMMI;
            c.alu_mode = ALU_ADD;
            c.ma_mode  = ir[5] ? MA_STORE : MA_LOAD;
            c.ma_size  = ma_size_t'(f3);
            c.wb_src   = ir[5] ? WB_SRC_X : WB_SRC_MEM;
            c.ra_used  = 1'b1;
            c.rb_used  = 1'b1;
        end
        7'b0001111: c.halt = 1'b0; // fence
        default:    c.halt = 1'b1;
    endcase
    c.ra_used = c.ra_used && (ir[19:15] != 5'd0);
    c.rb_used = c.rb_used && (ir[24:20] != 5'd0);
    return c;
endfunction

function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        3'd7:    return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic id_out_t nop_out();
    id_out_t o;
    o          = '0;
    o.ir       = `CPU_NOP_IR;
    o.alu_mode = ALU_ADD;
    o.ma_size  = MA_SIZE_X;
    return o;
endfunction

function automatic id_out_t expect_out(word_t pc, word_t ir, ctrl_word_t c, word_t a, word_t b);
    id_out_t o;
    o.pc = pc;
    o.ir = ir;
    case (c.alu_op1)
        ALU_OP1_RS1:  o.alu_op1 = a;
        ALU_OP1_IMMU: o.alu_op1 = imm_u_of(ir);
        default:      o.alu_op1 = '0;
    endcase
    case (c.alu_op2)
        ALU_OP2_RS2:  o.alu_op2 = b;
        ALU_OP2_IMMI: o.alu_op2 = imm_i_of(ir);
        ALU_OP2_IMMS: o.alu_op2 = imm_s_of(ir);
        ALU_OP2_PC:   o.alu_op2 = pc;
        default:      o.alu_op2 = '0;
    endcase
    o.alu_mode = c.alu_mode;
    o.ma_mode  = c.ma_mode;
    o.ma_size  = c.ma_size;
    o.ma_data  = b;
    o.wb_src   = c.wb_src;
    o.wb_data  = pc + 32'd4;
    o.wb_valid = (c.wb_src != WB_SRC_X) && (ir[11:7] != 5'd0);
    o.halt     = c.halt;
    return o;
endfunction

`endif

// ==== tb_cpu_id.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_id_macros.svh"

module tb_cpu_id
    import cpu_id_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTR    = 3000;

    logic     clk;
    logic     reset;
    word_t    pc;
    word_t    ir;
    ex_fwd_t  ex_fwd;
    wb_port_t wb;
    logic     ready;
    logic     jmp_valid;
    word_t    jmp_addr;
    id_out_t  id_out;

    `include "tb_cpu_id_model.svh"

    cpu_id dut0 (
        .clk_i       (clk),
        .reset_i     (reset),
        .pc_i        (pc),
        .ir_i        (ir),
        .ex_fwd_i    (ex_fwd),
        .wb_i        (wb),
        .ready_o     (ready),
        .jmp_valid_o (jmp_valid),
        .jmp_addr_o  (jmp_addr),
        .out_o       (id_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // twice the nominal run length, stalls included
    initial begin
        #(NUM_INSTR * CLK_PERIOD * 2);
        $display("timeout: %0d instructions did not complete in time", NUM_INSTR);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(string name, logic [255:0] expected, logic [255:0] actual);
        assert (actual === expected)
        else begin
            $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // x0..x7 only, so bypass matches are frequent
    function automatic regaddr_t small_reg();
        return regaddr_t'($urandom_range(0, 7));
    endfunction

    function automatic word_t random_instr();
        word_t      w;
        logic [6:0] op;
        case ($urandom_range(0, 11))
            0:       op = 7'b0110011;
            1:       op = 7'b0010011;
            2:       op = 7'b0110111;
            3:       op = 7'b0010111;
            4:       op = 7'b1101111;
            5:       op = 7'b1100111;
            6:       op = 7'b1100011;
            7:       op = 7'b0000011;
            8:       op = 7'b0100011;
            9:       op = 7'b0001111;
            10:      op = 7'b1110011; // system, undefined here
            default: op = 7'b0101111; // amo
        endcase
        w = $urandom();
        if ((op == 7'b0110011 || op == 7'b0010011) && $urandom_range(0, 3) != 0)
            w[31:25] = $urandom_range(0, 1) ? 7'h20 : 7'h00;
        w[24:20] = small_reg();
        w[19:15] = small_reg();
        w[11:7]  = small_reg();
        w[6:0]   = op;
        return w;
    endfunction

    function automatic ex_fwd_t random_ex();
        ex_fwd_t e;
        e.valid = 1'($urandom_range(0, 1));
        e.ready = 1'($urandom_range(0, 1));
        e.addr  = small_reg();
        e.data  = $urandom();
        return e;
    endfunction

    function automatic wb_port_t random_wb();
        wb_port_t p;
        p.valid = 1'($urandom_range(0, 1));
        p.addr  = small_reg();
        p.data  = $urandom();
        return p;
    endfunction

    initial begin
        ctrl_word_t  cw;
        word_t       a_val;
        word_t       b_val;
        word_t       exp_jaddr;
        logic        exp_jvalid;
        logic        exp_ready;
        logic        hazard;
        id_out_t     exp_out;
        int          done;

        void'($urandom(20304));
        reset     = 1'b1;
        pc        = '0;
        ir        = `CPU_NOP_IR;
        ex_fwd    = '0;
        wb        = '0;
        exp_out   = nop_out();
        exp_ready = 1'b1;

        // load x1..x7 through the write-back port while in reset
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #1;
            ir       = random_instr();
            ex_fwd   = random_ex();
            wb.valid = (i < 7);
            wb.addr  = regaddr_t'(i + 1);
            wb.data  = $urandom();
            #5;
            check_value("ready_o", 256'(1'b1), 256'(ready));
            check_value("jmp_valid_o", 256'(1'b0), 256'(jmp_valid));
            commit_write(wb);
        end

        done = 0;
        while (done < NUM_INSTR) begin
            @(posedge clk);
            #1;
            reset = 1'b0;
            if (exp_ready) begin // else hold the stalled instruction
                pc = $urandom() & 32'hffff_fffc;
                ir = random_instr();
            end
            ex_fwd = random_ex();
            wb     = random_wb();
            #5;

            cw     = expect_ctrl(ir);
            a_val  = forwarded_value(ir[19:15], ex_fwd, wb);
            b_val  = forwarded_value(ir[24:20], ex_fwd, wb);
            hazard = ex_fwd.valid && !ex_fwd.ready
                     && ((cw.ra_used && ex_fwd.addr == ir[19:15])
                         || (cw.rb_used && ex_fwd.addr == ir[24:20]));
            exp_ready = !hazard;

            case (cw.pc_mode)
                PC_JUMP_REL: begin
                    exp_jvalid = 1'b1;
                    exp_jaddr  = pc + imm_j_of(ir);
                end
                PC_JUMP_ABS: begin
                    exp_jvalid = !hazard;
                    exp_jaddr  = a_val + imm_i_of(ir);
                end
                PC_BRANCH: begin
                    exp_jvalid = !hazard && branch_taken(ir[14:12], a_val, b_val);
                    exp_jaddr  = pc + imm_b_of(ir);
                end
                default: begin
                    exp_jvalid = 1'b0;
                    exp_jaddr  = '0;
                end
            endcase

            check_value("out_o", 256'(exp_out), 256'(id_out));
            check_value("ready_o", 256'(exp_ready), 256'(ready));
            check_value("jmp_valid_o", 256'(exp_jvalid), 256'(jmp_valid));
            if (exp_jvalid)
                check_value("jmp_addr_o", 256'(exp_jaddr), 256'(jmp_addr));

            exp_out = hazard ? nop_out() : expect_out(pc, ir, cw, a_val, b_val);
            commit_write(wb); // lands in the array at the next edge
            if (exp_ready)
                done++;
        end

        // the last decode still sits in the stage register
        @(posedge clk);
        #6;
        check_value("out_o", 256'(exp_out), 256'(id_out));

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
